// File: boot_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module boot_ram (
	input  logic         clk_50mhz,
	bus_target_if.target bus
);
	import soc_bus_pkg::*;

	logic [`SOC_DATA_W-1:0] mem [`BOOT_DEPTH_WORDS];

	always_ff @(posedge clk_50mhz) begin
		if (bus.req) begin
			if (bus.write) begin
				for (int i = 0; i < `SOC_STRB_W; i++) begin
					if (bus.wstrb[i])
						mem[bus.word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end else begin
				bus.rdata <= mem[bus.word_addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module bus_fsm (
	input  logic                         clk_50mhz,
	input  logic                         resetn,
	input  logic [`SOC_ADDR_W-1:0]       awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`SOC_DATA_W-1:0]       wdata,
	input  logic [`SOC_STRB_W-1:0]       wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	input  logic [`SOC_ADDR_W-1:0]       araddr,
	input  logic                         arvalid,
	output logic                         arready,
	input  logic                         rd_full,
	input  logic                         wr_full,
	input  logic [2*`PAD_BUTTONS-1:0]    pad_state,
	output logic                         rd_push,
	output soc_bus_pkg::read_resp_t      rd_payload,
	output logic                         wr_push,
	output soc_bus_pkg::write_resp_t     wr_payload,
	bus_target_if.initiator              ram
);
	import soc_bus_pkg::*;

	localparam int                     WORD_W    = $clog2(`BOOT_DEPTH_WORDS);
	localparam logic [`SOC_ADDR_W-1:0] BOOT_ADDR = `BOOT_BASE;
	localparam logic [`SOC_ADDR_W-1:0] PAD_ADDR  = `PAD_BASE;

	typedef enum logic [1:0] {S_IDLE, S_READ_WAIT, S_PUSH} state_t;

	state_t      state;
	logic        is_read;
	logic        can_accept;
	logic        rd_go;
	logic        wr_go;
	region_e     ar_region;
	region_e     aw_region;
	region_e     rd_region;
	read_resp_t  rd_next;
	read_resp_t  rd_q;
	write_resp_t wr_q;

	function automatic region_e decode(input logic [`SOC_ADDR_W-1:0] addr);
		if (addr[`SOC_ADDR_W-1:`BOOT_REGION_BITS] == BOOT_ADDR[`SOC_ADDR_W-1:`BOOT_REGION_BITS])
			return REGION_BOOT;
		if (addr[`SOC_ADDR_W-1:`PAD_REGION_BITS] == PAD_ADDR[`SOC_ADDR_W-1:`PAD_REGION_BITS])
			return REGION_PAD;
		return REGION_NONE;
	endfunction

	assign ar_region = decode(araddr);
	assign aw_region = decode(awaddr);

	// Idle and no response still waiting downstream
	assign can_accept = (state == S_IDLE) && !rd_full && !wr_full;
	assign rd_go      = can_accept && arvalid;
	assign wr_go      = can_accept && !arvalid && awvalid && wvalid; // Read wins

	assign arready = can_accept;
	assign awready = wr_go;
	assign wready  = wr_go;

	// RAM access issued in the handshake cycle
	assign ram.req       = (rd_go && ar_region == REGION_BOOT) || (wr_go && aw_region == REGION_BOOT);
	assign ram.write     = !rd_go;
	assign ram.word_addr = rd_go ? araddr[WORD_W+1:2] : awaddr[WORD_W+1:2];
	assign ram.wdata     = wdata;
	assign ram.wstrb     = wstrb;

	always_comb begin
		case (rd_region)
			REGION_BOOT: rd_next = '{data: ram.rdata, resp: RESP_OKAY};
			REGION_PAD:  rd_next = '{data: `SOC_DATA_W'(pad_state), resp: RESP_OKAY};
			default:     rd_next = '{data: '0, resp: RESP_DECERR};
		endcase
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state   <= S_IDLE;
			is_read <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (rd_go) begin
						state   <= S_READ_WAIT;
						is_read <= 1'b1;
					end else if (wr_go) begin
						state   <= S_PUSH;
						is_read <= 1'b0;
					end
				end
				S_READ_WAIT: state <= S_PUSH;
				S_PUSH: begin
					if (is_read ? !rd_full : !wr_full)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_go)
			rd_region <= ar_region;
		if (state == S_READ_WAIT)
			rd_q <= rd_next; // RAM data lands here
		if (wr_go) begin
			case (aw_region)
				REGION_BOOT: wr_q.resp <= RESP_OKAY;
				REGION_PAD:  wr_q.resp <= RESP_SLVERR; // Pad register is read only
				default:     wr_q.resp <= RESP_DECERR;
			endcase
		end
	end

	assign rd_push    = (state == S_PUSH) && is_read && !rd_full;
	assign wr_push    = (state == S_PUSH) && !is_read && !wr_full;
	assign rd_payload = rd_q;
	assign wr_payload = wr_q;

endmodule

`default_nettype wire

// File: bus_target_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

interface bus_target_if;

	logic                                 req; // One cycle per access
	logic                                 write;
	logic [$clog2(`BOOT_DEPTH_WORDS)-1:0] word_addr;
	logic [`SOC_DATA_W-1:0]               wdata;
	logic [`SOC_STRB_W-1:0]               wstrb;
	logic [`SOC_DATA_W-1:0]               rdata; // Valid the cycle after a read req

	modport initiator (
		output req, write, word_addr, wdata, wstrb,
		input  rdata
	);

	modport target (
		input  req, write, word_addr, wdata, wstrb,
		output rdata
	);

endinterface

`default_nettype wire

// File: pad_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module pad_reader (
	input  logic                      clk_50mhz,
	input  logic                      resetn,
	input  logic                      tick,
	input  logic                      data,
	output logic                      latch,
	output logic                      clock,
	output soc_bus_pkg::pad_buttons_t buttons
);
	import soc_bus_pkg::*;

	// Step 0 latch, then clock low on odd steps and high on even steps
	localparam int LAST_STEP = 2 * `PAD_BUTTONS;
	localparam int STEP_W    = $clog2(LAST_STEP + 1);

	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] next_step;
	logic              rise;
	pad_buttons_t      shift;
	pad_buttons_t      shift_next;

	assign next_step  = (step == STEP_W'(LAST_STEP)) ? '0 : step + 1'b1;
	assign rise       = (next_step != '0) && !next_step[0];
	assign shift_next = {~data, shift[`PAD_BUTTONS-1:1]}; // Pins are active low

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			step    <= STEP_W'(LAST_STEP); // First tick starts a scan
			latch   <= 1'b0;
			clock   <= 1'b0;
			buttons <= '0;
		end else if (tick) begin
			step  <= next_step;
			latch <= (next_step == '0);
			clock <= rise;
			if (next_step == STEP_W'(LAST_STEP))
				buttons <= shift_next; // Last sample completes the byte
		end
	end

	// Sample before the pad shifts on this same clock edge
	always_ff @(posedge clk_50mhz) begin
		if (tick && rise)
			shift <= shift_next;
	end

endmodule

`default_nettype wire

// File: pad_tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module pad_tick_timer (
	input  logic clk_50mhz,
	input  logic resetn,
	output logic tick
);
	import soc_bus_pkg::*;

	localparam int CNT_W = $clog2(`PAD_TICK_DIV);

	logic [CNT_W-1:0] count;
	logic             wrap;

	assign wrap = (count == CNT_W'(`PAD_TICK_DIV - 1));

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= '0;
			tick  <= 1'b0;
		end else begin
			count <= wrap ? '0 : count + 1'b1;
			tick  <= wrap; // One cycle per period
		end
	end

endmodule

`default_nettype wire

// File: resp_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module resp_buffer #(
	parameter type payload_t = soc_bus_pkg::write_resp_t
) (
	input  logic     clk_50mhz,
	input  logic     resetn,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     full,
	output logic     valid,
	input  logic     ready,
	output payload_t payload
);
	import soc_bus_pkg::*;

	logic load;

	assign load  = in_valid && !full;
	assign valid = full;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;
		else if (ready)
			full <= 1'b0; // Drained by the bus handshake
	end

	always_ff @(posedge clk_50mhz) begin
		if (load)
			payload <= in_payload;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc_bus
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_soc_bus
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: soc_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module soc_bus_checker (
	input logic                   clk_50mhz,
	input logic                   resetn,
	input logic                   rvalid,
	input logic                   rready,
	input logic [`SOC_DATA_W-1:0] rdata,
	input logic [1:0]             rresp,
	input logic                   bvalid,
	input logic                   bready,
	input logic                   pad0_latch,
	input logic                   pad0_clock,
	input logic                   pad1_latch,
	input logic                   pad1_clock
);

	rvalid_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rvalid && !rready |=> rvalid) else $error("rvalid fell before rready");

	bvalid_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bvalid && !bready |=> bvalid) else $error("bvalid fell before bready");

	// Payload frozen while the response is stalled
	rdata_stable: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rvalid && !rready |=> $stable(rdata) && $stable(rresp)) else $error("read payload moved");

	pad0_pins: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!(pad0_latch && pad0_clock)) else $error("pad0 latch and clock both high");

	pad1_pins: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!(pad1_latch && pad1_clock)) else $error("pad1 latch and clock both high");

	reset_quiet: assert property (@(posedge clk_50mhz)
		!resetn |=> !rvalid && !bvalid) else $error("response valid after reset");

endmodule

`default_nettype wire

// File: soc_bus_config.svh
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// 64 KB bootloader window over a 4 KB array
`define BOOT_BASE 32'h0201_0000
`define BOOT_REGION_BITS 16
`define BOOT_DEPTH_WORDS 1024

// Game-pad status register
`define PAD_BASE 32'h0200_0200
`define PAD_REGION_BITS 2

`define PAD_TICK_DIV 512 // 50 MHz / 512
`define PAD_BUTTONS 8

`endif

// File: soc_bus_pkg.sv
`default_nettype none

`include "soc_bus_config.svh"

package soc_bus_pkg;

	// Decoded target of one transaction
	typedef enum logic [1:0] {
		REGION_BOOT,
		REGION_PAD,
		REGION_NONE
	} region_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_e;

	typedef logic [`PAD_BUTTONS-1:0] pad_buttons_t; // 1 = pressed

	typedef struct packed {
		logic [`SOC_DATA_W-1:0] data;
		resp_e                  resp;
	} read_resp_t;

	typedef struct packed {
		resp_e resp;
	} write_resp_t;

endpackage

`default_nettype wire

// File: soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

module soc_bus_top (
	input  logic                   clk_50mhz,
	input  logic                   resetn,

	input  logic [`SOC_ADDR_W-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [`SOC_DATA_W-1:0] wdata,
	input  logic [`SOC_STRB_W-1:0] wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [`SOC_ADDR_W-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [`SOC_DATA_W-1:0] rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,

	output logic                   pad0_latch,
	output logic                   pad0_clock,
	input  logic                   pad0_data,
	output logic                   pad1_latch,
	output logic                   pad1_clock,
	input  logic                   pad1_data
);
	import soc_bus_pkg::*;

	logic                        tick;
	pad_buttons_t                pad0_buttons;
	pad_buttons_t                pad1_buttons;
	logic [2*`PAD_BUTTONS-1:0]   pad_state;
	logic                        rd_push;
	logic                        rd_full;
	read_resp_t                  rd_payload;
	read_resp_t                  rd_out;
	logic                        wr_push;
	logic                        wr_full;
	write_resp_t                 wr_payload;
	write_resp_t                 wr_out;

	bus_target_if ram_bus ();

	assign pad_state = {pad1_buttons, pad0_buttons};

	bus_fsm u_bus_fsm (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rd_full   (rd_full),
		.wr_full   (wr_full),
		.pad_state (pad_state),
		.rd_push   (rd_push),
		.rd_payload(rd_payload),
		.wr_push   (wr_push),
		.wr_payload(wr_payload),
		.ram       (ram_bus)
	);

	boot_ram u_boot_ram (
		.clk_50mhz(clk_50mhz),
		.bus      (ram_bus)
	);

	resp_buffer #(.payload_t(read_resp_t)) u_rd_buf (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.in_valid  (rd_push),
		.in_payload(rd_payload),
		.full      (rd_full),
		.valid     (rvalid),
		.ready     (rready),
		.payload   (rd_out)
	);

	resp_buffer #(.payload_t(write_resp_t)) u_wr_buf (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.in_valid  (wr_push),
		.in_payload(wr_payload),
		.full      (wr_full),
		.valid     (bvalid),
		.ready     (bready),
		.payload   (wr_out)
	);

	assign rdata = rd_out.data;
	assign rresp = rd_out.resp;
	assign bresp = wr_out.resp;

	pad_tick_timer u_pad_tick (
		.clk_50mhz(clk_50mhz),
		.resetn   (resetn),
		.tick     (tick)
	);

	pad_reader u_pad0 (
		.clk_50mhz(clk_50mhz),
		.resetn   (resetn),
		.tick     (tick),
		.data     (pad0_data),
		.latch    (pad0_latch),
		.clock    (pad0_clock),
		.buttons  (pad0_buttons)
	);

	pad_reader u_pad1 (
		.clk_50mhz(clk_50mhz),
		.resetn   (resetn),
		.tick     (tick),
		.data     (pad1_data),
		.latch    (pad1_latch),
		.clock    (pad1_clock),
		.buttons  (pad1_buttons)
	);

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
soc_bus_pkg.sv
bus_target_if.sv
bus_fsm.sv
pad_tick_timer.sv
pad_reader.sv
boot_ram.sv
resp_buffer.sv
soc_bus_top.sv
soc_bus_checker.sv
tb_soc_bus.sv

// File: tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_config.svh"

// Game-pad model that shifts out the inverted buttons bit 0 first
module pad_model (
	input  logic       latch,
	input  logic       clock,
	input  logic [7:0] buttons,
	output logic       data
);
	logic [7:0] shreg = 8'hFF; // Released buttons read high

	always @(posedge latch or posedge clock) begin
		if (latch)
			shreg <= ~buttons;
		else
			shreg <= {1'b1, shreg[7:1]};
	end

	assign data = shreg[0];
endmodule

module tb_soc_bus;
	localparam int          PAD_WAIT        = 40 * `PAD_TICK_DIV;
	localparam int          WATCHDOG_CYCLES = 60000; // Pad wait plus bus traffic and margin
	localparam logic [31:0] BOOT_ADDR       = `BOOT_BASE;
	localparam logic [31:0] PAD_ADDR        = `PAD_BASE;

	logic        clk_50mhz;
	logic        resetn;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        pad0_latch;
	logic        pad0_clock;
	logic        pad0_data;
	logic        pad1_latch;
	logic        pad1_clock;
	logic        pad1_data;
	logic [7:0]  pad0_btn;
	logic [7:0]  pad1_btn;
	logic [31:0] lcg_state;
	logic [31:0] exp_mem [16]; // Byte-wise RAM model

	soc_bus_top i_dut (.*);

	pad_model i_pad0_model (
		.latch  (pad0_latch),
		.clock  (pad0_clock),
		.buttons(pad0_btn),
		.data   (pad0_data)
	);

	pad_model i_pad1_model (
		.latch  (pad1_latch),
		.clock  (pad1_clock),
		.buttons(pad1_btn),
		.data   (pad1_data)
	);

	bind soc_bus_top soc_bus_checker i_checker (.*);

	always #10 clk_50mhz = ~clk_50mhz;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		return result;
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s got 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_50mhz);
		#1;
	endtask

	task automatic read_addr(input logic [31:0] addr);
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready)
			next_cycle();
		next_cycle(); // Handshake edge
		arvalid = 1'b0;
	endtask

	// Lat counts edges from the handshake to rvalid
	task automatic read_resp(output logic [31:0] data, output logic [1:0] resp, output int lat);
		lat = 0;
		while (!rvalid) begin
			next_cycle();
			lat++;
		end
		data = rdata;
		resp = rresp;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp, output int lat);
		read_addr(addr);
		read_resp(data, resp, lat);
		next_cycle(); // Drains with rready high
	endtask

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp, output int lat);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!awready)
			next_cycle();
		check(32'(wready), 32'd1, "wready with awready");
		next_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		lat     = 0;
		while (!bvalid) begin
			next_cycle();
			lat++;
		end
		resp = bresp;
		next_cycle();
	endtask

	task automatic set_pads(input logic [7:0] pad0, input logic [7:0] pad1);
		pad0_btn = pad0;
		pad1_btn = pad1;
	endtask

	task automatic reset_defaults();
		logic [31:0] data;
		logic [1:0]  resp;
		int          lat;
		check(32'(rvalid), 32'd0, "rvalid after reset");
		check(32'(bvalid), 32'd0, "bvalid after reset");
		check(32'({pad0_latch, pad0_clock, pad1_latch, pad1_clock}), 32'd0, "pad pins after reset");
		axil_read(PAD_ADDR, data, resp, lat);
		check(data, 32'd0, "pad register after reset");
		check(32'(resp), 32'd0, "pad read resp");
	endtask

	task automatic ram_readback();
		logic [31:0] data;
		logic [31:0] rnd;
		logic [1:0]  resp;
		int          lat;
		for (int i = 0; i < 16; i++) begin // Full words first since the array starts undefined
			exp_mem[i] = next_random();
			axil_write(BOOT_ADDR + 32'(4 * i), exp_mem[i], 4'hF, resp, lat);
			check(32'(resp), 32'd0, "RAM write resp");
			check(32'(lat), 32'd1, "write latency");
		end
		for (int i = 0; i < 16; i++) begin
			data       = next_random();
			rnd        = next_random();
			exp_mem[i] = merge_bytes(exp_mem[i], data, rnd[3:0]);
			axil_write(BOOT_ADDR + 32'(4 * i), data, rnd[3:0], resp, lat);
			check(32'(resp), 32'd0, "RAM strobe write resp");
		end
		for (int i = 0; i < 16; i++) begin
			axil_read(BOOT_ADDR + 32'(4 * i), data, resp, lat);
			check(data, exp_mem[i], $sformatf("RAM word %0d", i));
			check(32'(resp), 32'd0, "RAM read resp");
			axil_read(BOOT_ADDR + 32'h1000 + 32'(4 * i), data, resp, lat); // 4 KB alias
			check(data, exp_mem[i], $sformatf("aliased RAM word %0d", i));
		end
	endtask

	task automatic pad_scan();
		logic [31:0] data;
		logic [1:0]  resp;
		int          lat;
		set_pads(8'hA5, 8'h3C);
		repeat (PAD_WAIT)
			@(posedge clk_50mhz);
		#1;
		axil_read(PAD_ADDR, data, resp, lat);
		check(data, 32'h0000_3CA5, "pad register");
		check(32'(resp), 32'd0, "pad read resp");
	endtask

	task automatic error_responses();
		logic [31:0] data;
		logic [31:0] guard;
		logic [1:0]  resp;
		int          lat;
		guard = next_random();
		// RAM word that shares its index bits with the pad address
		axil_write(BOOT_ADDR + (PAD_ADDR & 32'h0FFC), guard, 4'hF, resp, lat);
		axil_read(32'h0300_0000, data, resp, lat);
		check(32'(resp), 32'd3, "unmapped read resp");
		check(data, 32'd0, "unmapped read data");
		axil_write(PAD_ADDR, 32'hFFFF_FFFF, 4'hF, resp, lat);
		check(32'(resp), 32'd2, "pad write resp");
		axil_write(32'h0400_0000, 32'hDEAD_BEEF, 4'hF, resp, lat);
		check(32'(resp), 32'd3, "unmapped write resp");
		for (int i = 0; i < 16; i++) begin
			axil_read(BOOT_ADDR + 32'(4 * i), data, resp, lat);
			check(data, exp_mem[i], $sformatf("RAM word %0d after failed writes", i));
		end
		axil_read(BOOT_ADDR + (PAD_ADDR & 32'h0FFC), data, resp, lat);
		check(data, guard, "RAM word under pad address after failed writes");
	endtask

	task automatic read_backpressure();
		logic [31:0] data;
		logic [1:0]  resp;
		int          lat;
		rready = 1'b0;
		read_addr(BOOT_ADDR + 32'd8);
		read_resp(data, resp, lat);
		check(32'(lat), 32'd2, "read latency");
		check(data, exp_mem[2], "stalled read data");
		repeat (10) begin
			next_cycle();
			check(32'(rvalid), 32'd1, "rvalid during stall");
			check(rdata, exp_mem[2], "rdata during stall");
			check(32'(arready), 32'd0, "arready during stall");
		end
		rready = 1'b1;
		next_cycle();
		check(32'(rvalid), 32'd0, "rvalid after drain");
		exp_mem[8] = next_random();
		axil_write(BOOT_ADDR + 32'h20, exp_mem[8], 4'hF, resp, lat);
		check(32'(lat), 32'd1, "write latency");
		check(32'(resp), 32'd0, "write resp");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk_50mhz);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk_50mhz  = 1'b0;
		resetn     = 1'b0;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b1;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b1;
		pad0_btn   = '0;
		pad1_btn   = '0;
		lcg_state  = 32'd13;
		repeat (2)
			@(posedge clk_50mhz);
		#1 resetn = 1'b1;
		reset_defaults();
		ram_readback();
		pad_scan();
		error_responses();
		read_backpressure();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
